// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the SFP CPLD testbench with Verilator.
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f verilog.f --top-module tb_sfp_cpld -o tb_sfp_cpld
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/tb_sfp_cpld > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if grep -q "TEST FAILED" "$LOG"; then
	exit 1
fi
exit 0

// File: source/cpld_pkg.sv
/* CPLD shared definitions */
`default_nettype none

package cpld_pkg;

	// ----------------------------------------
	// widths with a meaning
	// ----------------------------------------
	typedef logic [9:0] lbus_addr_t;	// local-bus address
	typedef logic [7:0] lbus_data_t;	// register data byte
	typedef logic [7:0] port_vec_t;	// one bit per sfp cage
	typedef logic [3:0] int_src_t;	// {los, abs, adt75, lm80}, all active low

	// ----------------------------------------
	// register map
	// ----------------------------------------
	localparam lbus_addr_t ADDR_TEST     = 10'h000;	// inverted readback
	localparam lbus_addr_t ADDR_VERSION  = 10'h002;	// read only
	localparam lbus_addr_t ADDR_INT_SRC  = 10'h027;	// read clear
	localparam lbus_addr_t ADDR_INT_MASK = 10'h028;
	localparam lbus_addr_t ADDR_TXDIS    = 10'h040;
	localparam lbus_addr_t ADDR_LED_LINK = 10'h041;
	localparam lbus_addr_t ADDR_LED_ACT  = 10'h042;
	localparam lbus_addr_t ADDR_SFP_ABS  = 10'h050;	// filtered abs pins
	localparam lbus_addr_t ADDR_SFP_LOS  = 10'h051;	// filtered los pins
	localparam lbus_addr_t ADDR_ABS_EVT  = 10'h052;	// read clear
	localparam lbus_addr_t ADDR_LOS_EVT  = 10'h053;	// read clear

	// logic revision
	localparam lbus_data_t LOGIC_VERSION = 8'h01;

	// ----------------------------------------
	// reset values
	// ----------------------------------------
	localparam lbus_data_t RST_INT_MASK = 8'hFF;	// all sources enabled
	localparam lbus_data_t RST_TXDIS    = 8'hFF;	// lasers off
	localparam lbus_data_t RST_LED      = 8'hFF;
	localparam lbus_data_t RST_TEST     = 8'h00;

endpackage

`default_nettype wire

// File: source/int_ctrl.sv
/* Interrupt source and output */
`default_nettype none

module int_ctrl (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               lm80,
	input  logic               adt75,
	input  logic               abs_summary_n,
	input  logic               los_summary_n,
	input  logic               src_clr,
	input  cpld_pkg::int_src_t int_mask,
	output cpld_pkg::int_src_t int_src,
	output logic               int_n
);
	import cpld_pkg::*;

	logic [1:0] sens_meta;	// {adt75, lm80} first flop
	logic [1:0] sens_sync;	// {adt75, lm80} safe to use
	int_src_t   live_src;	// masked sources ahead of the register

	// ----------------------------------------
	// sensor alarm sync
	// ----------------------------------------
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			sens_meta <= '1;	// alarms idle high
			sens_sync <= '1;
		end
		else
		begin
			sens_meta <= {adt75, lm80};
			sens_sync <= sens_meta;
		end
	end

	// masked-off source reads as inactive
	assign live_src = {los_summary_n, abs_summary_n, sens_sync} | ~int_mask;

	// ----------------------------------------
	// source register and pin
	// ----------------------------------------
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			int_src <= '1;
			int_n   <= 1'b1;
		end
		else
		begin
			if (src_clr)
				int_src <= '1;	// read-clear, refills next clock
			else
				int_src <= live_src;
			int_n <= &int_src;	// any low source asserts
		end
	end

endmodule

`default_nettype wire

// File: source/lbus_regs.sv
/* Local-bus register file */
`default_nettype none

module lbus_regs (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 cs_n,
	input  logic                 rd_n,
	input  logic                 wr_n,
	input  cpld_pkg::lbus_addr_t addr,
	input  cpld_pkg::lbus_data_t wdata,
	input  cpld_pkg::port_vec_t  abs_filt,
	input  cpld_pkg::port_vec_t  los_filt,
	input  cpld_pkg::port_vec_t  abs_evt,
	input  cpld_pkg::port_vec_t  los_evt,
	input  cpld_pkg::int_src_t   int_src,
	output cpld_pkg::lbus_data_t rdata,
	output cpld_pkg::int_src_t   int_mask,
	output cpld_pkg::port_vec_t  txdis,
	output cpld_pkg::port_vec_t  led_link,
	output cpld_pkg::port_vec_t  led_act,
	output logic                 abs_clr,
	output logic                 los_clr,
	output logic                 src_clr
);
	import cpld_pkg::*;

	logic       rd_act;	// read strobe inside chip select
	logic       wr_act;	// write strobe inside chip select
	logic [2:0] rc_hit;	// {src, los, abs} clearable address match
	logic [2:0] rc_flag;	// clearable reg read during this strobe
	logic [2:0] rc_pulse;	// registered clear pulses
	lbus_data_t test_q;	// scratch, stores inverted data
	lbus_data_t mask_q;	// full byte kept, low nibble drives int_ctrl

	assign rd_act   = ~cs_n & ~rd_n;
	assign wr_act   = ~cs_n & ~wr_n;
	assign rc_hit   = {addr == ADDR_INT_SRC, addr == ADDR_LOS_EVT, addr == ADDR_ABS_EVT};
	assign int_mask = mask_q[$bits(int_src_t)-1:0];
	assign {src_clr, los_clr, abs_clr} = rc_pulse;

	// ----------------------------------------
	// write side
	// ----------------------------------------
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			test_q   <= RST_TEST;
			mask_q   <= RST_INT_MASK;
			txdis    <= RST_TXDIS;
			led_link <= RST_LED;
			led_act  <= RST_LED;
		end
		else if (wr_act)
		begin
			case (addr)
				ADDR_TEST:     test_q   <= ~wdata;	// cpu sees complement
				ADDR_INT_MASK: mask_q   <= wdata;
				ADDR_TXDIS:    txdis    <= wdata;	// straight to sfp pins
				ADDR_LED_LINK: led_link <= wdata;	// 1 forces led off
				ADDR_LED_ACT:  led_act  <= wdata;	// 1 forces led on
				default:       ;	// read-only or unmapped
			endcase
		end
	end

	// ----------------------------------------
	// read mux, registered
	// ----------------------------------------
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			rdata <= '0;
		else if (rd_act)
		begin
			case (addr)
				ADDR_TEST:     rdata <= test_q;
				ADDR_VERSION:  rdata <= LOGIC_VERSION;
				ADDR_INT_SRC:  rdata <= {4'hF, int_src};	// spare bits idle high
				ADDR_INT_MASK: rdata <= mask_q;
				ADDR_TXDIS:    rdata <= txdis;
				ADDR_LED_LINK: rdata <= led_link;
				ADDR_LED_ACT:  rdata <= led_act;
				ADDR_SFP_ABS:  rdata <= abs_filt;
				ADDR_SFP_LOS:  rdata <= los_filt;
				ADDR_ABS_EVT:  rdata <= abs_evt;
				ADDR_LOS_EVT:  rdata <= los_evt;
				default:       rdata <= '0;	// unmapped
			endcase
		end
	end

	// ----------------------------------------
	// read-clear
	// ----------------------------------------
	// flag collects hits while the strobe is low, the pulse fires once it rises
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			rc_flag  <= '0;
			rc_pulse <= '0;
		end
		else if (rd_act)
		begin
			rc_flag  <= rc_flag | rc_hit;
			rc_pulse <= '0;
		end
		else
		begin
			rc_pulse <= rc_flag;	// single clock, flag drops now
			rc_flag  <= '0;
		end
	end

	// host never reads and writes within one select
	a_one_strobe: assert property (@(posedge clk) disable iff (!rst_n)
		!cs_n |-> (rd_n | wr_n));

endmodule

`default_nettype wire

// File: source/port_led_ctrl.sv
/* Port LED drive and tick */
`default_nettype none

module port_led_ctrl #(
	parameter int TICK_DIV = 2_500_000	// clk cycles per tick
) (
	input  logic                clk,
	input  logic                rst_n,
	input  cpld_pkg::port_vec_t led_link,
	input  cpld_pkg::port_vec_t led_act,
	output logic                tick,
	output cpld_pkg::port_vec_t led
);
	import cpld_pkg::*;

	localparam int CNT_W = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;

	typedef logic [CNT_W-1:0] div_cnt_t;	// tick divider count

	div_cnt_t cnt;
	logic     blink;	// toggles every tick

	// ----------------------------------------
	// tick divider
	// ----------------------------------------
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			cnt  <= '0;
			tick <= 1'b0;
		end
		else if (cnt == div_cnt_t'(TICK_DIV - 1))
		begin
			cnt  <= '0;
			tick <= 1'b1;	// one clock wide
		end
		else
		begin
			cnt  <= cnt + 1'b1;
			tick <= 1'b0;
		end
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			blink <= 1'b1;
		else if (tick)
			blink <= ~blink;
	end

	// link=1 off, else act=1 on, else blink; leds are active low
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			led <= '1;
		else
			led <= led_link | (~led_act & {$bits(port_vec_t){blink}});
	end

endmodule

`default_nettype wire

// File: source/sfp_cpld_top.sv
/* SFP line-card CPLD top */
`default_nettype none

module sfp_cpld_top #(
	parameter int TICK_DIV = 2_500_000	// about 0.1 s at 25 MHz
) (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 cs_n,
	input  logic                 rd_n,
	input  logic                 wr_n,
	input  logic                 lm80,
	input  logic                 adt75,
	input  cpld_pkg::lbus_addr_t addr,
	input  cpld_pkg::lbus_data_t wdata,
	input  cpld_pkg::port_vec_t  sfp_abs,
	input  cpld_pkg::port_vec_t  sfp_los,
	output cpld_pkg::lbus_data_t rdata,
	output logic                 int_n,
	output cpld_pkg::port_vec_t  txdis,
	output cpld_pkg::port_vec_t  led
);
	import cpld_pkg::*;

	int_src_t  int_mask;
	int_src_t  int_src;
	port_vec_t led_link;
	port_vec_t led_act;
	port_vec_t abs_filt;
	port_vec_t abs_evt;
	port_vec_t los_filt;
	port_vec_t los_evt;
	logic      abs_clr;	// read-clear pulses
	logic      los_clr;
	logic      src_clr;
	logic      abs_summary_n;
	logic      los_summary_n;
	logic      tick;	// debounce and blink rate

	// ----------------------------------------
	// bus side
	// ----------------------------------------
	lbus_regs lbus_regs_i (
		.clk(clk), .rst_n(rst_n),
		.cs_n(cs_n), .rd_n(rd_n), .wr_n(wr_n), .addr(addr), .wdata(wdata),
		.abs_filt(abs_filt), .los_filt(los_filt),
		.abs_evt(abs_evt), .los_evt(los_evt), .int_src(int_src),
		.rdata(rdata), .int_mask(int_mask), .txdis(txdis),
		.led_link(led_link), .led_act(led_act),
		.abs_clr(abs_clr), .los_clr(los_clr), .src_clr(src_clr)
	);

	// ----------------------------------------
	// cage monitors, abs and los in parallel
	// ----------------------------------------
	sfp_status_mon abs_mon_i (
		.clk(clk), .rst_n(rst_n), .tick(tick), .clr(abs_clr), .pins(sfp_abs),
		.filt(abs_filt), .evt(abs_evt), .summary_n(abs_summary_n)
	);

	sfp_status_mon los_mon_i (
		.clk(clk), .rst_n(rst_n), .tick(tick), .clr(los_clr), .pins(sfp_los),
		.filt(los_filt), .evt(los_evt), .summary_n(los_summary_n)
	);

	int_ctrl int_ctrl_i (
		.clk(clk), .rst_n(rst_n), .lm80(lm80), .adt75(adt75),
		.abs_summary_n(abs_summary_n), .los_summary_n(los_summary_n),
		.src_clr(src_clr), .int_mask(int_mask),
		.int_src(int_src), .int_n(int_n)
	);

	port_led_ctrl #(
		.TICK_DIV(TICK_DIV)
	) port_led_ctrl_i (
		.clk(clk), .rst_n(rst_n), .led_link(led_link), .led_act(led_act),
		.tick(tick), .led(led)
	);

endmodule

`default_nettype wire

// File: source/sfp_status_mon.sv
/* SFP pin debounce and events */
`default_nettype none

module sfp_status_mon (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                tick,
	input  logic                clr,
	input  cpld_pkg::port_vec_t pins,
	output cpld_pkg::port_vec_t filt,
	output cpld_pkg::port_vec_t evt,
	output logic                summary_n
);
	import cpld_pkg::*;

	port_vec_t samp;	// pin sample from last tick
	port_vec_t filt_d;	// filt delayed one clock
	port_vec_t chg_n;	// one-clock low per changed bit

	// ----------------------------------------
	// debounce on the slow tick
	// ----------------------------------------
	// two equal samples one tick apart pass to filt
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			samp <= '1;	// cages idle high
			filt <= '1;
		end
		else if (tick)
		begin
			if (pins == samp)
				filt <= samp;	// stable for a full tick
			else
				samp <= pins;	// moved, restart
		end
	end

	// ----------------------------------------
	// change detect
	// ----------------------------------------
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			filt_d <= '1;
			chg_n  <= '1;
		end
		else
		begin
			filt_d <= filt;
			chg_n  <= ~(filt ^ filt_d);	// either direction counts
		end
	end

	// ----------------------------------------
	// event latch and summary
	// ----------------------------------------
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			evt       <= '1;
			summary_n <= 1'b1;
		end
		else
		begin
			if (clr)
				evt <= chg_n;	// a change landing on the clear is kept
			else
				evt <= evt & chg_n;	// sticky low
			summary_n <= &evt;	// low while any port pending
		end
	end

	// events only go back high through a read-clear from the bus
	a_evt_sticky: assert property (@(posedge clk) disable iff (!rst_n)
		(|(evt & ~$past(evt))) |-> $past(clr));

endmodule

`default_nettype wire

// File: verif/tb_sfp_cpld.sv
/* SFP CPLD testbench */
`default_nettype none

module tb_sfp_cpld;
	timeunit 1ns;
	timeprecision 1ps;
	import cpld_pkg::*;

	localparam int TICK_DIV  = 16;	// short tick for simulation
	localparam int MAX_STEPS = 64;
	localparam int S_WR      = 0;	// bus write
	localparam int S_RD      = 1;	// bus read and compare
	localparam int S_PINS    = 2;	// addr picks abs/los/lm80/adt75
	localparam int S_WAIT    = 3;	// data = number of ticks
	localparam int S_CHK     = 4;	// data masks the output picked by addr
	localparam int S_BLINK   = 5;	// led bits in mask toggle within 4 ticks

	logic       clk = 1'b0;
	logic       rst_n;
	logic       cs_n;
	logic       rd_n;
	logic       wr_n;
	logic       lm80;
	logic       adt75;
	lbus_addr_t addr;
	lbus_data_t wdata;
	port_vec_t  sfp_abs;
	port_vec_t  sfp_los;
	lbus_data_t rdata;
	logic       int_n;
	port_vec_t  txdis;
	port_vec_t  led;

	int          step_kind [MAX_STEPS];
	lbus_addr_t  step_addr [MAX_STEPS];
	lbus_data_t  step_data [MAX_STEPS];
	lbus_data_t  step_exp  [MAX_STEPS];
	int          n_steps = 0;
	int          errors  = 0;
	int          cycles  = 0;
	int          limit   = 0;	// set once the table is built
	logic [31:0] lcg_state = 32'd51;

	sfp_cpld_top #(
		.TICK_DIV(TICK_DIV)
	) dut_i (
		.clk(clk), .rst_n(rst_n), .cs_n(cs_n), .rd_n(rd_n), .wr_n(wr_n),
		.lm80(lm80), .adt75(adt75), .addr(addr), .wdata(wdata),
		.sfp_abs(sfp_abs), .sfp_los(sfp_los),
		.rdata(rdata), .int_n(int_n), .txdis(txdis), .led(led)
	);

	always #5 clk = ~clk;	// 100 MHz

	// run limit allows 4 ticks per step
	always @(posedge clk)
	begin
		cycles++;
		if (limit > 0 && cycles > limit)
		begin
			$display("timeout: run did not finish within %0d cycles", limit);
			$display("TEST FAILED");
			$finish;
		end
	end

	function automatic lbus_data_t lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state[23:16];	// upper bits spread better
	endfunction

	task automatic check(input string what, input lbus_data_t got,
			input lbus_data_t expv);
		if (got !== expv)
		begin
			errors++;
			$display("FAILED at %0t ns: %s got 0x%02h expected 0x%02h",
				$time, what, got, expv);
		end
	endtask

	task automatic add_step(input int k, input lbus_addr_t a, input lbus_data_t d,
			input lbus_data_t e);
		step_kind[n_steps] = k;
		step_addr[n_steps] = a;
		step_data[n_steps] = d;
		step_exp[n_steps]  = e;
		n_steps++;
	endtask

	// ----------------------------------------
	// bus cycles of one strobe clock and a gap
	// ----------------------------------------
	task automatic bus_write(input lbus_addr_t a, input lbus_data_t d);
		@(negedge clk);
		cs_n  = 1'b0;
		wr_n  = 1'b0;
		addr  = a;
		wdata = d;
		@(negedge clk);
		cs_n = 1'b1;
		wr_n = 1'b1;
		repeat (2) @(negedge clk);	// let read-clear and pipelines settle
	endtask

	task automatic bus_read(input lbus_addr_t a, output lbus_data_t d);
		@(negedge clk);
		cs_n = 1'b0;
		rd_n = 1'b0;
		addr = a;
		@(negedge clk);
		cs_n = 1'b1;
		rd_n = 1'b1;
		d    = rdata;	// registered on the rising edge just passed
		repeat (2) @(negedge clk);	// clear pulse lands here
	endtask

	task automatic watch_blink(input lbus_data_t mask, input int idx);
		logic seen_hi;
		logic seen_lo;
		seen_hi = 1'b0;
		seen_lo = 1'b0;
		repeat (4 * TICK_DIV)
		begin
			@(negedge clk);
			if ((led & mask) == mask)
				seen_hi = 1'b1;
			if ((led & mask) == 8'h00)
				seen_lo = 1'b1;
		end
		check($sformatf("step %0d led blink high seen", idx),
			{7'd0, seen_hi}, 8'h01);
		check($sformatf("step %0d led blink low seen", idx),
			{7'd0, seen_lo}, 8'h01);
	endtask

	task automatic build_table();
		lbus_data_t r;
		// reset values
		add_step(S_CHK, 10'd0, 8'h01, 8'h01);	// int_n
		add_step(S_CHK, 10'd1, 8'hFF, 8'hFF);	// txdis
		add_step(S_CHK, 10'd2, 8'hFF, 8'hFF);	// led
		add_step(S_RD, ADDR_VERSION, 8'h00, 8'h01);
		add_step(S_RD, ADDR_INT_MASK, 8'h00, 8'hFF);
		add_step(S_RD, ADDR_TXDIS, 8'h00, 8'hFF);
		add_step(S_RD, ADDR_TEST, 8'h00, 8'h00);
		add_step(S_RD, ADDR_ABS_EVT, 8'h00, 8'hFF);
		add_step(S_RD, ADDR_LOS_EVT, 8'h00, 8'hFF);
		// random register access
		r = lcg_next();
		add_step(S_WR, ADDR_TEST, r, 8'h00);
		add_step(S_RD, ADDR_TEST, 8'h00, ~r);	// scratch reads inverted
		r = lcg_next();
		add_step(S_WR, ADDR_TXDIS, r, 8'h00);
		add_step(S_RD, ADDR_TXDIS, 8'h00, r);
		add_step(S_CHK, 10'd1, 8'hFF, r);
		r = lcg_next();
		add_step(S_WR, ADDR_INT_MASK, r, 8'h00);
		add_step(S_RD, ADDR_INT_MASK, 8'h00, r);
		add_step(S_WR, ADDR_INT_MASK, 8'hFF, 8'h00);	// back to all enabled
		// led[3:0] on and led[7:4] blinking
		add_step(S_WR, ADDR_LED_LINK, 8'h00, 8'h00);
		add_step(S_WR, ADDR_LED_ACT, 8'h0F, 8'h00);
		add_step(S_CHK, 10'd2, 8'h0F, 8'h00);
		add_step(S_BLINK, 10'd0, 8'hF0, 8'h00);
		add_step(S_WR, ADDR_LED_LINK, 8'hFF, 8'h00);
		add_step(S_CHK, 10'd2, 8'hFF, 8'hFF);
		// abs event and read-clear
		add_step(S_PINS, 10'd0, 8'hF5, 8'h00);
		add_step(S_WAIT, 10'd0, 8'd3, 8'h00);
		add_step(S_CHK, 10'd0, 8'h01, 8'h00);	// int_n asserted
		add_step(S_RD, ADDR_SFP_ABS, 8'h00, 8'hF5);
		add_step(S_RD, ADDR_INT_SRC, 8'h00, 8'hFB);	// abs summary bit low
		add_step(S_RD, ADDR_ABS_EVT, 8'h00, 8'hF5);	// ports 1 and 3 changed
		add_step(S_RD, ADDR_ABS_EVT, 8'h00, 8'hFF);
		add_step(S_RD, ADDR_INT_SRC, 8'h00, 8'hFF);
		add_step(S_CHK, 10'd0, 8'h01, 8'h01);
		// los event masked then unmasked
		add_step(S_WR, ADDR_INT_MASK, 8'h07, 8'h00);
		add_step(S_PINS, 10'd1, 8'h7F, 8'h00);
		add_step(S_WAIT, 10'd0, 8'd3, 8'h00);
		add_step(S_CHK, 10'd0, 8'h01, 8'h01);	// masked so int_n stays high
		add_step(S_RD, ADDR_SFP_LOS, 8'h00, 8'h7F);
		add_step(S_WR, ADDR_INT_MASK, 8'h0F, 8'h00);
		add_step(S_CHK, 10'd0, 8'h01, 8'h00);
		add_step(S_RD, ADDR_LOS_EVT, 8'h00, 8'h7F);	// bit 7 on its own bit
		add_step(S_RD, ADDR_LOS_EVT, 8'h00, 8'hFF);
		add_step(S_CHK, 10'd0, 8'h01, 8'h01);
		// lm80 alarm
		add_step(S_PINS, 10'd2, 8'h00, 8'h00);
		add_step(S_WAIT, 10'd0, 8'd1, 8'h00);
		add_step(S_CHK, 10'd0, 8'h01, 8'h00);
		add_step(S_RD, ADDR_INT_SRC, 8'h00, 8'hFE);
		add_step(S_PINS, 10'd2, 8'h01, 8'h00);
		add_step(S_WAIT, 10'd0, 8'd1, 8'h00);
		add_step(S_RD, ADDR_INT_SRC, 8'h00, 8'hFF);
		add_step(S_CHK, 10'd0, 8'h01, 8'h01);
	endtask

	// ----------------------------------------
	// main sequence
	// ----------------------------------------
	initial
	begin
		lbus_data_t got;
		lbus_data_t outv;
		rst_n   = 1'b0;
		cs_n    = 1'b1;
		rd_n    = 1'b1;
		wr_n    = 1'b1;
		lm80    = 1'b1;	// alarms idle high
		adt75   = 1'b1;
		addr    = '0;
		wdata   = '0;
		sfp_abs = 8'hFF;
		sfp_los = 8'hFF;
		build_table();
		limit = n_steps * 4 * TICK_DIV + 500;
		repeat (4) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		for (int i = 0; i < n_steps; i++)
		begin
			case (step_kind[i])
				S_WR:
					bus_write(step_addr[i], step_data[i]);
				S_RD:
				begin
					bus_read(step_addr[i], got);
					check($sformatf("step %0d read 0x%03h", i, step_addr[i]),
						got, step_exp[i]);
				end
				S_PINS:
				begin
					@(negedge clk);
					case (step_addr[i])
						10'd0:   sfp_abs = step_data[i];
						10'd1:   sfp_los = step_data[i];
						10'd2:   lm80    = step_data[i][0];
						default: adt75   = step_data[i][0];
					endcase
				end
				S_WAIT:
					repeat (int'(step_data[i]) * TICK_DIV) @(negedge clk);
				S_CHK:
				begin
					repeat (2) @(negedge clk);	// outputs are registered
					case (step_addr[i])
						10'd0:   outv = {7'd0, int_n};
						10'd1:   outv = txdis;
						default: outv = led;
					endcase
					check($sformatf("step %0d output %0d", i, step_addr[i]),
						outv & step_data[i], step_exp[i]);
				end
				default:
					watch_blink(step_data[i], i);
			endcase
		end
		$display("errors: %0d in %0d steps", errors, n_steps);
		if (errors == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: verilog.f
source/cpld_pkg.sv
source/lbus_regs.sv
source/sfp_status_mon.sv
source/int_ctrl.sv
source/port_led_ctrl.sv
source/sfp_cpld_top.sv
verif/tb_sfp_cpld.sv
